/* src/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

   // word shared by the front end and the back end
   localparam int DATA_W = 32;

   // byte lanes per word, also the width of wstrb
   localparam int NBYTES = DATA_W / 8;

   // default word-address width
   localparam int DEF_ADDR_W = 12;

   // 8 sets
   localparam int DEF_NSETS_W = 3;

   // 4 words per line
   localparam int DEF_BLK_SIZE_W = 2;

   // 2 ways
   localparam int DEF_NWAYS_W = 1;

endpackage

`default_nettype wire

/* src/cache_ctrl_pkg.sv */
`default_nettype none

package cache_ctrl_pkg;

   // controller FSM states
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      FILL_REQ,
      FILL_WAIT,
      FILL_DONE,
      WRITE_THRU
   } ctrl_state_t;

   // back-end strobe for the reads of a line fill
   localparam logic [cache_geom_pkg::NBYTES-1:0] FILL_WSTRB = '0;

endpackage

`default_nettype wire

/* src/cache_req_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_req_stage #(
   parameter int ADDR_W = cache_geom_pkg::DEF_ADDR_W,
   parameter int NSETS_W = cache_geom_pkg::DEF_NSETS_W,
   parameter int BLK_SIZE_W = cache_geom_pkg::DEF_BLK_SIZE_W,
   localparam int TAG_W = ADDR_W - NSETS_W - BLK_SIZE_W
) (
   input  wire                                   clk_i,
   input  wire                                   rst_i,
   input  wire                                   avalid_i,
   input  wire [ADDR_W-1:0]                      addr_i,
   input  wire [cache_geom_pkg::NBYTES-1:0]      wstrb_i,
   input  wire [cache_geom_pkg::DATA_W-1:0]      wdata_i,
   input  wire                                   ready_i,
   output logic                                  req_valid_o,
   output logic [TAG_W-1:0]                      tag_o,
   output logic [NSETS_W-1:0]                    index_o,
   output logic [BLK_SIZE_W-1:0]                 offset_o,
   output logic [cache_geom_pkg::NBYTES-1:0]     wstrb_o,
   output logic [cache_geom_pkg::DATA_W-1:0]     wdata_o,
   output logic                                  is_write_o,
   output logic [NSETS_W-1:0]                    index_now_o,
   output logic [BLK_SIZE_W-1:0]                 offset_now_o
);

   logic accept;

   assign accept = avalid_i & ready_i;

   // address layout is {tag, index, offset}
   assign index_now_o  = addr_i[BLK_SIZE_W +: NSETS_W];
   assign offset_now_o = addr_i[BLK_SIZE_W-1:0];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         req_valid_o <= 1'b0;
      end else begin
         req_valid_o <= accept;
      end
   end

   // held until the next accepted request
   always_ff @(posedge clk_i) begin
      if (accept) begin
         tag_o    <= addr_i[ADDR_W-1 -: TAG_W];
         index_o  <= index_now_o;
         offset_o <= offset_now_o;
         wstrb_o  <= wstrb_i;
         wdata_o  <= wdata_i;
      end
   end

   assign is_write_o = |wstrb_o;

endmodule

`default_nettype wire

/* src/cache_sp_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_sp_ram #(
   parameter type payload_t = logic [31:0],
   parameter int DEPTH_W = 4
) (
   input  wire               clk_i,
   input  wire               en_i,
   input  wire               we_i,
   input  wire [DEPTH_W-1:0] addr_i,
   input  wire payload_t     d_i,
   output payload_t          q_o
);

   payload_t mem [2**DEPTH_W];

   // read-first, q_o valid one cycle after the address
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i) begin
            mem[addr_i] <= d_i;
         end
         q_o <= mem[addr_i];
      end
   end

endmodule

`default_nettype wire

/* src/cache_way_select.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_way_select #(
   parameter int ADDR_W = cache_geom_pkg::DEF_ADDR_W,
   parameter int NSETS_W = cache_geom_pkg::DEF_NSETS_W,
   parameter int BLK_SIZE_W = cache_geom_pkg::DEF_BLK_SIZE_W,
   parameter int NWAYS_W = cache_geom_pkg::DEF_NWAYS_W,
   localparam int TAG_W = ADDR_W - NSETS_W - BLK_SIZE_W,
   localparam int NWAYS = 2**NWAYS_W,
   localparam int NSETS = 2**NSETS_W
) (
   input  wire                clk_i,
   input  wire                rst_i,
   input  wire                invalidate_i,
   input  wire [TAG_W-1:0]    tags_i [NWAYS],
   input  wire [TAG_W-1:0]    tag_i,
   input  wire [NSETS_W-1:0]  index_i,
   input  wire                fill_en_i,
   output logic               hit_o,
   output logic [NWAYS_W-1:0] hit_way_o,
   output logic [NWAYS_W-1:0] victim_way_o
);

   logic [NWAYS-1:0]   valid [NSETS];
   logic [NWAYS_W-1:0] rr_ptr [NSETS];
   logic [NWAYS-1:0]   hit_vec;

   // valid bits, invalidate wins over a fill
   always_ff @(posedge clk_i) begin
      if (rst_i || invalidate_i) begin
         for (int s = 0; s < NSETS; s++) begin
            valid[s] <= '0;
         end
      end else if (fill_en_i) begin
         valid[index_i][victim_way_o] <= 1'b1;
      end
   end

   // round-robin victim per set
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int s = 0; s < NSETS; s++) begin
            rr_ptr[s] <= '0;
         end
      end else if (fill_en_i) begin
         rr_ptr[index_i] <= rr_ptr[index_i] + NWAYS_W'(1);
      end
   end

   // tag compare on the RAM outputs of the lookup cycle
   always_comb begin
      hit_way_o = '0;
      for (int w = 0; w < NWAYS; w++) begin
         hit_vec[w] = valid[index_i][w] && (tags_i[w] == tag_i);
         if (hit_vec[w]) begin
            hit_way_o = NWAYS_W'(w);
         end
      end
   end

   assign hit_o        = |hit_vec;
   assign victim_way_o = rr_ptr[index_i];

endmodule

`default_nettype wire

/* src/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
   parameter int NSETS_W = cache_geom_pkg::DEF_NSETS_W,
   parameter int BLK_SIZE_W = cache_geom_pkg::DEF_BLK_SIZE_W,
   parameter int NWAYS_W = cache_geom_pkg::DEF_NWAYS_W,
   localparam int NWAYS = 2**NWAYS_W,
   localparam int RAM_AW = NSETS_W + BLK_SIZE_W,
   localparam int DW = cache_geom_pkg::DATA_W,
   localparam int NB = cache_geom_pkg::NBYTES
) (
   input  wire                   clk_i,
   input  wire                   rst_i,
   input  wire                   avalid_i,
   input  wire                   req_valid_i,
   input  wire                   is_write_i,
   input  wire [NSETS_W-1:0]     index_i,
   input  wire [BLK_SIZE_W-1:0]  offset_i,
   input  wire [NSETS_W-1:0]     index_now_i,
   input  wire [BLK_SIZE_W-1:0]  offset_now_i,
   input  wire [NB-1:0]          wstrb_i,
   input  wire [DW-1:0]          wdata_i,
   input  wire                   hit_i,
   input  wire [NWAYS_W-1:0]     hit_way_i,
   input  wire [NWAYS_W-1:0]     victim_way_i,
   input  wire [DW-1:0]          ram_rdata_i [NWAYS],
   input  wire                   fill_word_valid_i,
   input  wire [DW-1:0]          fill_word_i,
   input  wire [BLK_SIZE_W-1:0]  fill_offset_i,
   input  wire                   mem_done_i,
   output logic                  ready_o,
   output logic                  rvalid_o,
   output logic [DW-1:0]         rdata_o,
   output logic [NWAYS-1:0]      tag_we_o,
   output logic                  data_en_o,
   output logic [NWAYS-1:0]      data_we_o,
   output logic [RAM_AW-1:0]     data_addr_o,
   output logic [DW-1:0]         data_d_o,
   output logic                  fill_en_o,
   output logic                  mem_start_o,
   output logic                  mem_write_o,
   output logic                  rd_hit_o,
   output logic                  rd_miss_o,
   output logic                  wr_hit_o,
   output logic                  wr_miss_o
);

   cache_ctrl_pkg::ctrl_state_t state;

   logic             lookup;
   logic [DW-1:0]    hit_word;
   logic [DW-1:0]    merged;
   logic [NWAYS-1:0] hit_1hot;
   logic [NWAYS-1:0] victim_1hot;

   assign lookup      = req_valid_i && (state == cache_ctrl_pkg::LOOKUP);
   assign hit_word    = ram_rdata_i[hit_way_i];
   assign hit_1hot    = NWAYS'(1) << hit_way_i;
   assign victim_1hot = NWAYS'(1) << victim_way_i;

   // write hit, new bytes over the cached word
   always_comb begin
      merged = hit_word;
      for (int b = 0; b < NB; b++) begin
         if (wstrb_i[b]) begin
            merged[8*b +: 8] = wdata_i[8*b +: 8];
         end
      end
   end

   // event pulses and back-end start, all in the lookup cycle
   assign rd_hit_o    = lookup & ~is_write_i & hit_i;
   assign rd_miss_o   = lookup & ~is_write_i & ~hit_i;
   assign wr_hit_o    = lookup & is_write_i & hit_i;
   assign wr_miss_o   = lookup & is_write_i & ~hit_i;
   assign mem_start_o = lookup & (is_write_i | ~hit_i);
   assign mem_write_o = is_write_i;

   assign ready_o  = (state == cache_ctrl_pkg::IDLE) && !rvalid_o;

   // RAM port, fill words take precedence
   always_comb begin
      data_en_o   = 1'b0;
      data_we_o   = '0;
      data_addr_o = {index_i, offset_i};
      data_d_o    = merged;
      tag_we_o    = '0;
      fill_en_o   = 1'b0;
      if (fill_word_valid_i) begin
         data_en_o   = 1'b1;
         data_we_o   = victim_1hot;
         data_addr_o = {index_i, fill_offset_i};
         data_d_o    = fill_word_i;
      end else begin
         case (state)
            cache_ctrl_pkg::IDLE: begin
               data_en_o   = avalid_i & ready_o;
               data_addr_o = {index_now_i, offset_now_i};
            end
            cache_ctrl_pkg::LOOKUP: begin
               data_en_o = wr_hit_o;
               data_we_o = wr_hit_o ? hit_1hot : '0;
            end
            // whole line is in, now the tag and valid bit
            cache_ctrl_pkg::FILL_DONE: begin
               data_en_o = 1'b1;
               tag_we_o  = victim_1hot;
               fill_en_o = 1'b1;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state    <= cache_ctrl_pkg::IDLE;
         rvalid_o <= 1'b0;
      end else begin
         rvalid_o <= 1'b0;
         case (state)
            cache_ctrl_pkg::IDLE:
               if (avalid_i && ready_o) state <= cache_ctrl_pkg::LOOKUP;
            cache_ctrl_pkg::LOOKUP:
               if (is_write_i) begin
                  state <= cache_ctrl_pkg::WRITE_THRU;
               end else if (hit_i) begin
                  state    <= cache_ctrl_pkg::IDLE;
                  rvalid_o <= 1'b1;
               end else begin
                  state <= cache_ctrl_pkg::FILL_REQ;
               end
            cache_ctrl_pkg::FILL_REQ:
               state <= cache_ctrl_pkg::FILL_WAIT;
            cache_ctrl_pkg::FILL_WAIT:
               if (mem_done_i) state <= cache_ctrl_pkg::FILL_DONE;
            cache_ctrl_pkg::FILL_DONE: begin
               state    <= cache_ctrl_pkg::IDLE;
               rvalid_o <= 1'b1;
            end
            cache_ctrl_pkg::WRITE_THRU:
               if (mem_done_i) state <= cache_ctrl_pkg::IDLE;
            default:
               state <= cache_ctrl_pkg::IDLE;
         endcase
      end
   end

   // hit word, or the requested word as it passes during a fill
   always_ff @(posedge clk_i) begin
      if (state == cache_ctrl_pkg::LOOKUP) begin
         rdata_o <= hit_word;
      end else if (fill_word_valid_i && (fill_offset_i == offset_i)) begin
         rdata_o <= fill_word_i;
      end
   end

endmodule

`default_nettype wire

/* src/cache_mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_mem_if #(
   parameter int ADDR_W = cache_geom_pkg::DEF_ADDR_W,
   parameter int BLK_SIZE_W = cache_geom_pkg::DEF_BLK_SIZE_W,
   localparam int LINE_W = ADDR_W - BLK_SIZE_W,
   localparam int DW = cache_geom_pkg::DATA_W,
   localparam int NB = cache_geom_pkg::NBYTES
) (
   input  wire                  clk_i,
   input  wire                  rst_i,
   input  wire                  start_i,
   input  wire                  write_i,
   input  wire [LINE_W-1:0]     line_addr_i,
   input  wire [BLK_SIZE_W-1:0] offset_i,
   input  wire [DW-1:0]         wdata_i,
   input  wire [NB-1:0]         wstrb_i,
   output logic                 be_avalid_o,
   output logic [ADDR_W-1:0]    be_addr_o,
   output logic [DW-1:0]        be_wdata_o,
   output logic [NB-1:0]        be_wstrb_o,
   input  wire                  be_ready_i,
   input  wire [DW-1:0]         be_rdata_i,
   input  wire                  be_rvalid_i,
   output logic                 fill_word_valid_o,
   output logic [DW-1:0]        fill_word_o,
   output logic [BLK_SIZE_W-1:0] fill_offset_o,
   output logic                 done_o
);

   logic                  wr_mode;
   logic                  be_fire;
   logic [LINE_W-1:0]     line_r;
   logic [BLK_SIZE_W-1:0] off_r;
   logic [BLK_SIZE_W-1:0] rcv_cnt;
   logic [NB-1:0]         wstrb_r;

   assign be_fire = be_avalid_o & be_ready_i;

   // request issue, one word per back-end read
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         be_avalid_o <= 1'b0;
         wr_mode     <= 1'b0;
         off_r       <= '0;
         rcv_cnt     <= '0;
      end else if (start_i) begin
         be_avalid_o <= 1'b1;
         wr_mode     <= write_i;
         off_r       <= write_i ? offset_i : '0;
         rcv_cnt     <= '0;
      end else begin
         if (be_fire) begin
            if (wr_mode || (off_r == '1)) be_avalid_o <= 1'b0;
            else off_r <= off_r + BLK_SIZE_W'(1);
         end
         if (be_rvalid_i) rcv_cnt <= rcv_cnt + BLK_SIZE_W'(1);
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         line_r     <= line_addr_i;
         be_wdata_o <= wdata_i;
         wstrb_r    <= wstrb_i;
      end
   end

   assign be_addr_o  = {line_r, off_r};
   assign be_wstrb_o = wr_mode ? wstrb_r : cache_ctrl_pkg::FILL_WSTRB;

   // fill words return in order
   assign fill_word_valid_o = be_rvalid_i & ~wr_mode;
   assign fill_word_o       = be_rdata_i;
   assign fill_offset_o     = rcv_cnt;

   assign done_o = (wr_mode & be_fire) | (fill_word_valid_o & (rcv_cnt == '1));

endmodule

`default_nettype wire

/* src/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
   parameter int ADDR_W = cache_geom_pkg::DEF_ADDR_W,
   parameter int NSETS_W = cache_geom_pkg::DEF_NSETS_W,
   parameter int BLK_SIZE_W = cache_geom_pkg::DEF_BLK_SIZE_W,
   parameter int NWAYS_W = cache_geom_pkg::DEF_NWAYS_W,
   localparam int TAG_W = ADDR_W - NSETS_W - BLK_SIZE_W,
   localparam int NWAYS = 2**NWAYS_W,
   localparam int RAM_AW = NSETS_W + BLK_SIZE_W,
   localparam int DW = cache_geom_pkg::DATA_W,
   localparam int NB = cache_geom_pkg::NBYTES
) (
   input  wire               clk_i,
   input  wire               rst_i,
   input  wire               avalid_i,
   input  wire [ADDR_W-1:0]  addr_i,
   input  wire [NB-1:0]      wstrb_i,
   input  wire [DW-1:0]      wdata_i,
   output logic              ready_o,
   output logic              rvalid_o,
   output logic [DW-1:0]     rdata_o,
   output logic              be_avalid_o,
   output logic [ADDR_W-1:0] be_addr_o,
   output logic [DW-1:0]     be_wdata_o,
   output logic [NB-1:0]     be_wstrb_o,
   input  wire               be_ready_i,
   input  wire [DW-1:0]      be_rdata_i,
   input  wire               be_rvalid_i,
   input  wire               invalidate_i,
   output logic              rd_hit_o,
   output logic              rd_miss_o,
   output logic              wr_hit_o,
   output logic              wr_miss_o
);

   logic                  req_valid, is_write, hit, data_en, fill_en;
   logic                  mem_start, mem_write, fill_word_valid, mem_done;
   logic [TAG_W-1:0]      tag_r;
   logic [NSETS_W-1:0]    index_r, index_now;
   logic [BLK_SIZE_W-1:0] offset_r, offset_now, fill_offset;
   logic [NB-1:0]         wstrb_r;
   logic [DW-1:0]         wdata_r, data_d, fill_word;
   logic [NWAYS_W-1:0]    hit_way, victim_way;
   logic [NWAYS-1:0]      tag_we, data_we;
   logic [RAM_AW-1:0]     data_addr;
   logic [TAG_W-1:0]      tag_q [NWAYS];
   logic [DW-1:0]         data_q [NWAYS];

   cache_req_stage #(.ADDR_W(ADDR_W), .NSETS_W(NSETS_W), .BLK_SIZE_W(BLK_SIZE_W)) u_req (
      .clk_i, .rst_i, .avalid_i, .addr_i, .wstrb_i, .wdata_i, .ready_i(ready_o),
      .req_valid_o(req_valid), .tag_o(tag_r), .index_o(index_r), .offset_o(offset_r),
      .wstrb_o(wstrb_r), .wdata_o(wdata_r), .is_write_o(is_write),
      .index_now_o(index_now), .offset_now_o(offset_now)
   );

   // invalidate only between requests
   cache_way_select #(
      .ADDR_W(ADDR_W), .NSETS_W(NSETS_W), .BLK_SIZE_W(BLK_SIZE_W), .NWAYS_W(NWAYS_W)
   ) u_ways (
      .clk_i, .rst_i, .invalidate_i(invalidate_i & ready_o), .tags_i(tag_q), .tag_i(tag_r),
      .index_i(index_r), .fill_en_i(fill_en), .hit_o(hit), .hit_way_o(hit_way),
      .victim_way_o(victim_way)
   );

   cache_ctrl #(.NSETS_W(NSETS_W), .BLK_SIZE_W(BLK_SIZE_W), .NWAYS_W(NWAYS_W)) u_ctrl (
      .clk_i, .rst_i, .avalid_i, .req_valid_i(req_valid), .is_write_i(is_write),
      .index_i(index_r), .offset_i(offset_r), .index_now_i(index_now),
      .offset_now_i(offset_now), .wstrb_i(wstrb_r), .wdata_i(wdata_r), .hit_i(hit),
      .hit_way_i(hit_way), .victim_way_i(victim_way), .ram_rdata_i(data_q),
      .fill_word_valid_i(fill_word_valid), .fill_word_i(fill_word),
      .fill_offset_i(fill_offset), .mem_done_i(mem_done), .ready_o, .rvalid_o, .rdata_o,
      .tag_we_o(tag_we), .data_en_o(data_en), .data_we_o(data_we), .data_addr_o(data_addr),
      .data_d_o(data_d), .fill_en_o(fill_en), .mem_start_o(mem_start),
      .mem_write_o(mem_write), .rd_hit_o, .rd_miss_o, .wr_hit_o, .wr_miss_o
   );

   cache_mem_if #(.ADDR_W(ADDR_W), .BLK_SIZE_W(BLK_SIZE_W)) u_mem (
      .clk_i, .rst_i, .start_i(mem_start), .write_i(mem_write),
      .line_addr_i({tag_r, index_r}), .offset_i(offset_r), .wdata_i(wdata_r),
      .wstrb_i(wstrb_r), .be_avalid_o, .be_addr_o, .be_wdata_o, .be_wstrb_o, .be_ready_i,
      .be_rdata_i, .be_rvalid_i, .fill_word_valid_o(fill_word_valid),
      .fill_word_o(fill_word), .fill_offset_o(fill_offset), .done_o(mem_done)
   );

   // tag RAM shares the set part of the data address
   for (genvar w = 0; w < NWAYS; w++) begin : g_way
      cache_sp_ram #(.payload_t(logic [TAG_W-1:0]), .DEPTH_W(NSETS_W)) u_tag_ram (
         .clk_i, .en_i(data_en), .we_i(tag_we[w]), .addr_i(data_addr[RAM_AW-1 -: NSETS_W]),
         .d_i(tag_r), .q_o(tag_q[w])
      );
      cache_sp_ram #(.payload_t(logic [DW-1:0]), .DEPTH_W(RAM_AW)) u_data_ram (
         .clk_i, .en_i(data_en), .we_i(data_we[w]), .addr_i(data_addr),
         .d_i(data_d), .q_o(data_q[w])
      );
   end

endmodule

`default_nettype wire

/* sim/cache_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_properties (
   input wire                          clk_i,
   input wire                          rst_i,
   input wire cache_ctrl_pkg::ctrl_state_t state_i,
   input wire                          ready_i,
   input wire                          rvalid_i,
   input wire                          is_write_i,
   input wire                          mem_start_i
);

   // failed assertions, summed into the closing report of the testbench
   int unsigned fail_cnt = 0;

   // the front end reopens in the cycle after rvalid
   a_ready_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
      !(ready_i && rvalid_i) && (!$past(rvalid_i) || ready_i))
      else begin
         fail_cnt++;
         $error("ready_o high with rvalid_o, or low in the cycle after rvalid_o");
      end

   // write requests complete without rvalid
   a_rvalid_read: assert property (@(posedge clk_i) disable iff (rst_i)
      rvalid_i |-> !is_write_i)
      else begin
         fail_cnt++;
         $error("rvalid_o after a write request");
      end

   // a back-end start leads into a fill or a write-through
   a_start_state: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_start_i |=>
         ($past(state_i) == cache_ctrl_pkg::IDLE || $past(state_i) == cache_ctrl_pkg::LOOKUP)
         && (state_i == cache_ctrl_pkg::FILL_REQ || state_i == cache_ctrl_pkg::WRITE_THRU))
      else begin
         fail_cnt++;
         $error("mem_start_o outside IDLE and LOOKUP or not followed by a back-end wait");
      end

   a_legal_state: assert property (@(posedge clk_i) disable iff (rst_i)
      state_i inside {cache_ctrl_pkg::IDLE, cache_ctrl_pkg::LOOKUP,
                      cache_ctrl_pkg::FILL_REQ, cache_ctrl_pkg::FILL_WAIT,
                      cache_ctrl_pkg::FILL_DONE, cache_ctrl_pkg::WRITE_THRU})
      else begin
         fail_cnt++;
         $error("controller state holds an illegal encoding");
      end

endmodule

bind cache_ctrl cache_properties u_props (
   .clk_i(clk_i),
   .rst_i(rst_i),
   .state_i(state),
   .ready_i(ready_o),
   .rvalid_i(rvalid_o),
   .is_write_i(is_write_i),
   .mem_start_i(mem_start_o)
);

`default_nettype wire

/* sim/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

   localparam int ADDR_W = cache_geom_pkg::DEF_ADDR_W;
   localparam int NSETS_W = cache_geom_pkg::DEF_NSETS_W;
   localparam int BLK_W = cache_geom_pkg::DEF_BLK_SIZE_W;
   localparam int DW = cache_geom_pkg::DATA_W;
   localparam int NB = cache_geom_pkg::NBYTES;
   localparam int NWORDS = 2**ADDR_W;
   localparam int PERIOD = 20;
   localparam int N_RANDOM = 60;
   localparam int N_ACCESS = N_RANDOM + 20;
   // cycles for one line fill with back-end stalls and late read data
   localparam int FILL_COST = 48;
   localparam int TIMEOUT_NS = (N_ACCESS * FILL_COST + 10) * PERIOD;
   localparam int WANT_ANY = 0;
   localparam int WANT_HIT = 1;
   localparam int WANT_MISS = 2;

   logic              clk_i = 1'b0;
   logic              rst_i;
   logic              avalid_i;
   logic [ADDR_W-1:0] addr_i;
   logic [NB-1:0]     wstrb_i;
   logic [DW-1:0]     wdata_i;
   logic              invalidate_i;
   logic              ready_o, rvalid_o, be_avalid_o;
   logic [DW-1:0]     rdata_o, be_wdata_o;
   logic [ADDR_W-1:0] be_addr_o;
   logic [NB-1:0]     be_wstrb_o;
   logic              be_ready_i = 1'b0;
   logic              be_rvalid_i = 1'b0;
   logic [DW-1:0]     be_rdata_i = '0;
   logic              rd_hit_o, rd_miss_o, wr_hit_o, wr_miss_o;

   logic [DW-1:0]     be_mem [NWORDS];
   logic [DW-1:0]     ref_mem [NWORDS];
   logic [ADDR_W-1:0] rd_addr_q [$];
   int unsigned       rd_due_q [$];
   int unsigned       cyc = 0;
   int unsigned       last_due = 0;
   int                err_cnt = 0;

   always #(PERIOD / 2) clk_i = ~clk_i;

   cache_top #(
      .ADDR_W(ADDR_W), .NSETS_W(NSETS_W), .BLK_SIZE_W(BLK_W),
      .NWAYS_W(cache_geom_pkg::DEF_NWAYS_W)
   ) u_dut (
      .clk_i, .rst_i, .avalid_i, .addr_i, .wstrb_i, .wdata_i, .ready_o, .rvalid_o,
      .rdata_o, .be_avalid_o, .be_addr_o, .be_wdata_o, .be_wstrb_o, .be_ready_i,
      .be_rdata_i, .be_rvalid_i, .invalidate_i, .rd_hit_o, .rd_miss_o, .wr_hit_o,
      .wr_miss_o
   );

   // back-end memory, in-order read data after 0 to 3 idle cycles
   always @(negedge clk_i) begin : backend_model
      int unsigned due;
      cyc = cyc + 1;
      if (rd_due_q.size() > 0 && rd_due_q[0] == cyc) begin
         be_rvalid_i = 1'b1;
         be_rdata_i  = be_mem[rd_addr_q.pop_front()];
         void'(rd_due_q.pop_front());
      end else begin
         be_rvalid_i = 1'b0;
         be_rdata_i  = '0;
      end
      be_ready_i = ($urandom % 4) != 0;
      // request fires at the coming rising edge
      if (be_avalid_o === 1'b1 && be_ready_i) begin
         if (be_wstrb_o == '0) begin
            due = cyc + 1 + ($urandom % 4);
            if (due <= last_due) due = last_due + 1;
            last_due = due;
            rd_addr_q.push_back(be_addr_o);
            rd_due_q.push_back(due);
         end else begin
            for (int b = 0; b < NB; b++) begin
               if (be_wstrb_o[b]) be_mem[be_addr_o][8*b +: 8] = be_wdata_o[8*b +: 8];
            end
         end
      end
   end

   function automatic logic [DW-1:0] init_word(input int a);
      return {4'hC, 12'(a), ~12'(a), 4'h3};
   endfunction

   // word address is {tag, set, word}
   function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input int word);
      return ADDR_W'((tag << (NSETS_W + BLK_W)) | (set << BLK_W) | word);
   endfunction

   task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                             input string what);
      assert (got === exp) else begin
         err_cnt++;
         $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      assert (got === exp) else begin
         err_cnt++;
         $display("[ERROR] %0t ns: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic wait_ready();
      while (ready_o !== 1'b1) @(negedge clk_i);
   endtask

   task automatic read_expect(input logic [ADDR_W-1:0] addr, input int want);
      logic hit;
      logic miss;
      int   lat;
      wait_ready();
      avalid_i = 1'b1;
      addr_i   = addr;
      wstrb_i  = '0;
      @(negedge clk_i);
      avalid_i = 1'b0;
      hit  = rd_hit_o;
      miss = rd_miss_o;
      lat  = 1;
      while (rvalid_o !== 1'b1) begin
         @(negedge clk_i);
         lat++;
      end
      check_word(rdata_o, ref_mem[addr], $sformatf("read data at %h", addr));
      check_bit(hit ^ miss, 1'b1, "exactly one of rd_hit and rd_miss");
      if (want == WANT_HIT) begin
         check_bit(hit, 1'b1, $sformatf("rd_hit at %h", addr));
         check_word(DW'(lat), DW'(2), "rvalid cycles after a read hit");
      end else if (want == WANT_MISS) begin
         check_bit(miss, 1'b1, $sformatf("rd_miss at %h", addr));
      end
   endtask

   task automatic write_expect(input logic [ADDR_W-1:0] addr, input logic [DW-1:0] data,
                               input logic [NB-1:0] strb, input int want);
      logic hit;
      logic miss;
      wait_ready();
      avalid_i = 1'b1;
      addr_i   = addr;
      wstrb_i  = strb;
      wdata_i  = data;
      @(negedge clk_i);
      avalid_i = 1'b0;
      wstrb_i  = '0;
      hit  = wr_hit_o;
      miss = wr_miss_o;
      wait_ready();
      for (int b = 0; b < NB; b++) begin
         if (strb[b]) ref_mem[addr][8*b +: 8] = data[8*b +: 8];
      end
      check_bit(hit ^ miss, 1'b1, "exactly one of wr_hit and wr_miss");
      if (want == WANT_HIT) check_bit(hit, 1'b1, $sformatf("wr_hit at %h", addr));
      if (want == WANT_MISS) check_bit(miss, 1'b1, $sformatf("wr_miss at %h", addr));
   endtask

   task automatic idle_after_reset();
      check_bit(ready_o, 1'b1, "ready_o after reset");
      check_bit(rvalid_o, 1'b0, "rvalid_o after reset");
      check_bit(be_avalid_o, 1'b0, "be_avalid_o after reset");
      check_bit(rd_hit_o | rd_miss_o | wr_hit_o | wr_miss_o, 1'b0, "event pulses after reset");
   endtask

   task automatic miss_then_hit();
      read_expect(make_addr(5, 1, 0), WANT_MISS);
      read_expect(make_addr(5, 1, 2), WANT_HIT);
   endtask

   task automatic write_through_merge();
      write_expect(make_addr(5, 1, 2), 32'hDEAD_BEEF, 4'b0101, WANT_HIT);
      read_expect(make_addr(5, 1, 2), WANT_HIT);
      check_word(be_mem[make_addr(5, 1, 2)], ref_mem[make_addr(5, 1, 2)], "back-end copy");
      write_expect(make_addr(9, 6, 1), 32'h1234_5678, 4'b1100, WANT_MISS);
      read_expect(make_addr(9, 6, 1), WANT_MISS);
   endtask

   // two ways, so the third tag in set 3 replaces the first
   task automatic round_robin_evict();
      read_expect(make_addr(10, 3, 0), WANT_MISS);
      read_expect(make_addr(11, 3, 1), WANT_MISS);
      read_expect(make_addr(12, 3, 2), WANT_MISS);
      read_expect(make_addr(11, 3, 3), WANT_HIT);
      read_expect(make_addr(10, 3, 0), WANT_MISS);
   endtask

   task automatic invalidate_all();
      read_expect(make_addr(5, 1, 0), WANT_HIT);
      wait_ready();
      invalidate_i = 1'b1;
      @(negedge clk_i);
      invalidate_i = 1'b0;
      read_expect(make_addr(5, 1, 0), WANT_MISS);
   endtask

   // three tags over all sets keep the replacement busy
   task automatic random_mix();
      logic [ADDR_W-1:0] addr;
      logic [NB-1:0]     strb;
      for (int i = 0; i < N_RANDOM; i++) begin
         addr = ADDR_W'($urandom % 96);
         if ($urandom % 2) begin
            strb = NB'($urandom % 15 + 1);
            write_expect(addr, DW'($urandom), strb, WANT_ANY);
         end else begin
            read_expect(addr, WANT_ANY);
         end
      end
   endtask

   initial begin
      int unsigned prop_fails;
      void'($urandom(32'h3ad1));
      rst_i        = 1'b1;
      avalid_i     = 1'b0;
      addr_i       = '0;
      wstrb_i      = '0;
      wdata_i      = '0;
      invalidate_i = 1'b0;
      for (int a = 0; a < NWORDS; a++) begin
         be_mem[a]  = init_word(a);
         ref_mem[a] = init_word(a);
      end
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      idle_after_reset();
      miss_then_hit();
      write_through_merge();
      round_robin_evict();
      invalidate_all();
      random_mix();
      prop_fails = u_dut.u_ctrl.u_props.fail_cnt;
      $display("errors: %0d check, %0d assertion", err_cnt, prop_fails);
      if (err_cnt == 0 && prop_fails == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the tests did not complete within %0d ns", TIMEOUT_NS);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
src/cache_geom_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_req_stage.sv
src/cache_sp_ram.sv
src/cache_way_select.sv
src/cache_ctrl.sv
src/cache_mem_if.sv
src/cache_top.sv
sim/cache_properties.sv
sim/cache_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := cache_tb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
RUN_FLAGS  := +verilator+error+limit+1000
PASS_MSG   := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
